//--- include/acc_settings.svh
`ifndef ACC_SETTINGS_SVH
`define ACC_SETTINGS_SVH

// Array geometry
`define ACC_PE_SIZE      4
`define ACC_PSUM_WIDTH   32
`define ACC_DATA_WIDTH   8
`define ACC_SLICE_MSB    15   // Top bit of quantized slice

// Accumulation schedule
`define ACC_DEPTH        8    // One entry per output row
`define ACC_PASSES       3

// Output path
`define ACC_ROWQ_DEPTH   8
`define ACC_BUF_WORDS    64
`define ACC_ADDR_WIDTH   8    // Byte address, word index in [7:2]

`endif

//--- hdl/acc_pkg.sv
`default_nettype none

`include "acc_settings.svh"

package acc_pkg;

    // Signed partial sum from one PE column
    typedef logic signed [`ACC_PSUM_WIDTH-1:0] psum_t;

    // Quantized ofmap element
    typedef logic [`ACC_DATA_WIDTH-1:0] ofmap_elem_t;

    // One buffer word
    // writer packs it per lane, buffer and host treat it as a flat word
    typedef union packed {
        ofmap_elem_t [`ACC_PE_SIZE-1:0]           lanes;  // Lane 0 in [7:0]
        logic [`ACC_PE_SIZE*`ACC_DATA_WIDTH-1:0]  raw;
    } ofmap_word_u;

endpackage

`default_nettype wire

//--- hdl/wb_if.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

// Wishbone classic, single word, no byte selects
interface wb_if;

    logic                                     cyc;
    logic                                     stb;
    logic                                     we;
    logic [`ACC_ADDR_WIDTH-1:0]               adr;      // Byte address
    logic [`ACC_PE_SIZE*`ACC_DATA_WIDTH-1:0]  dat_m2s;  // Write data
    logic [`ACC_PE_SIZE*`ACC_DATA_WIDTH-1:0]  dat_s2m;  // Read data
    logic                                     ack;      // One cycle per transfer

    modport master (
        output cyc, stb, we, adr, dat_m2s,
        input  dat_s2m, ack
    );

    modport slave (
        input  cyc, stb, we, adr, dat_m2s,
        output dat_s2m, ack
    );

endinterface

`default_nettype wire

//--- hdl/psum_fifo.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module psum_fifo (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           wren_i,
    input  logic           rden_i,
    input  acc_pkg::psum_t wdata_i,
    output acc_pkg::psum_t rdata_o   // Head entry, show-ahead
);
    import acc_pkg::*;

    localparam int PTR_W = $clog2(`ACC_DEPTH);

    psum_t              mem [`ACC_DEPTH];
    logic [PTR_W-1:0]   wr_ptr;
    logic [PTR_W-1:0]   rd_ptr;

    // Pointers wrap each pass, so they line up again at tile end
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
        end else begin
            if (wren_i)
                wr_ptr <= (wr_ptr == PTR_W'(`ACC_DEPTH-1)) ? '0 : wr_ptr + 1'b1;
            if (rden_i)
                rd_ptr <= (rd_ptr == PTR_W'(`ACC_DEPTH-1)) ? '0 : rd_ptr + 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (wren_i) mem[wr_ptr] <= wdata_i;  // Middle pass rewrites the slot just read
    end

    assign rdata_o = mem[rd_ptr];  // Adder sees head same cycle

endmodule

`default_nettype wire

//--- hdl/psum_accumulator.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module psum_accumulator (
    input  logic                                  clk,
    input  logic                                  rst_n,
    input  logic [`ACC_PE_SIZE-1:0]               psum_en_i,   // Lane j is j cycles late
    input  acc_pkg::psum_t [`ACC_PE_SIZE-1:0]     psum_row_i,
    output logic                                  row_valid_o,
    output acc_pkg::ofmap_word_u                  row_data_o
);
    import acc_pkg::*;

    localparam int ENT_W  = $clog2(`ACC_DEPTH);
    localparam int PASS_W = $clog2(`ACC_PASSES);

    logic [ENT_W-1:0]               entry_cnt;
    logic [PASS_W-1:0]              pass_cnt;
    logic [`ACC_PE_SIZE-1:0]        first_ph;    // Per lane, pass 0
    logic [`ACC_PE_SIZE-1:0]        last_ph;     // Per lane, final pass
    logic [`ACC_PE_SIZE-1:1]        first_sr;
    logic [`ACC_PE_SIZE-1:1]        last_sr;
    ofmap_elem_t [`ACC_PE_SIZE-1:0] row_bytes;

    // Entry/pass position, tracked on lane 0 only
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            entry_cnt <= '0;
            pass_cnt  <= '0;
        end else if (psum_en_i[0]) begin
            if (entry_cnt == ENT_W'(`ACC_DEPTH-1)) begin
                entry_cnt <= '0;
                pass_cnt  <= (pass_cnt == PASS_W'(`ACC_PASSES-1)) ? '0 : pass_cnt + 1'b1;
            end else begin
                entry_cnt <= entry_cnt + 1'b1;
            end
        end
    end

    // Lane 0 phase is live, later lanes get it one stage per lane
    assign first_ph = {first_sr, pass_cnt == '0};
    assign last_ph  = {last_sr, pass_cnt == PASS_W'(`ACC_PASSES-1)};

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            first_sr <= '0;
            last_sr  <= '0;
        end else begin
            first_sr <= first_ph[`ACC_PE_SIZE-2:0];  // Tracks the skew
            last_sr  <= last_ph[`ACC_PE_SIZE-2:0];
        end
    end

    for (genvar k = 0; k < `ACC_PE_SIZE; k++) begin : g_lane
        psum_t       rdata;
        psum_t       feedback;
        psum_t       sum;
        ofmap_elem_t dsk [`ACC_PE_SIZE-k];   // Lane k waits PE_SIZE-1-k cycles

        assign feedback = first_ph[k] ? '0 : rdata;   // Preload on first pass
        assign sum      = feedback + psum_row_i[k];

        psum_fifo u_fifo (
            .clk     (clk),
            .rst_n   (rst_n),
            .wren_i  (psum_en_i[k] && !last_ph[k]),   // Final pass drains
            .rden_i  (psum_en_i[k] && !first_ph[k]),
            .wdata_i (sum),
            .rdata_o (rdata)
        );

        // Quantize and deskew
        always_ff @(posedge clk) begin
            if (psum_en_i[k] && last_ph[k])
                dsk[0] <= sum[`ACC_SLICE_MSB -: `ACC_DATA_WIDTH];  // No rounding
            for (int s = 1; s < `ACC_PE_SIZE-k; s++)
                dsk[s] <= dsk[s-1];
        end

        assign row_bytes[k] = dsk[`ACC_PE_SIZE-1-k];
    end

    // Row aligned once the last lane has captured its byte
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            row_valid_o <= 1'b0;
        else
            row_valid_o <= psum_en_i[`ACC_PE_SIZE-1] && last_ph[`ACC_PE_SIZE-1];
    end

    assign row_data_o.lanes = row_bytes;

endmodule

`default_nettype wire

//--- hdl/ofmap_writer.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module ofmap_writer (
    input  logic                 clk,
    input  logic                 rst_n,
    input  logic                 row_valid_i,  // No back-pressure
    input  acc_pkg::ofmap_word_u row_data_i,
    wb_if.master                 wb,
    output logic                 overflow_o    // Sticky
);
    import acc_pkg::*;

    localparam int QPTR_W = $clog2(`ACC_ROWQ_DEPTH);
    localparam int CNT_W  = $clog2(`ACC_ROWQ_DEPTH + 1);
    localparam int WADR_W = `ACC_ADDR_WIDTH - 2;

    ofmap_word_u         rowq [`ACC_ROWQ_DEPTH];
    logic [QPTR_W-1:0]   wr_ptr;
    logic [QPTR_W-1:0]   rd_ptr;
    logic [CNT_W-1:0]    count;
    logic [WADR_W-1:0]   word_adr;   // Next buffer word
    logic                busy;       // Write in flight
    logic                full;
    logic                push;
    logic                pop;

    assign full = (count == CNT_W'(`ACC_ROWQ_DEPTH));
    assign push = row_valid_i && !full;   // Row lost when full
    assign pop  = busy && wb.ack;         // Retire at ack

    always_ff @(posedge clk) begin
        if (push) rowq[wr_ptr].lanes <= row_data_i.lanes;
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wr_ptr     <= '0;
            rd_ptr     <= '0;
            count      <= '0;
            word_adr   <= '0;
            busy       <= 1'b0;
            overflow_o <= 1'b0;
        end else begin
            if (push) wr_ptr <= wr_ptr + 1'b1;
            if (pop) begin
                rd_ptr   <= rd_ptr + 1'b1;
                word_adr <= (word_adr == WADR_W'(`ACC_BUF_WORDS-1)) ? '0 : word_adr + 1'b1;
            end
            case ({push, pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
            // stb drops the cycle after ack
            if (pop)
                busy <= 1'b0;
            else if (!busy && count != '0)
                busy <= 1'b1;
            if (row_valid_i && full) overflow_o <= 1'b1;
        end
    end

    assign wb.cyc     = busy;
    assign wb.stb     = busy;
    assign wb.we      = 1'b1;                  // Write only master
    assign wb.adr     = {word_adr, 2'b00};
    assign wb.dat_m2s = rowq[rd_ptr].raw;      // Held until ack

endmodule

`default_nettype wire

//--- hdl/wb_arbiter.sv
`timescale 1ns/1ps
`default_nettype none

module wb_arbiter (
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  m0,   // Writer, high priority
    wb_if.slave  m1,   // Host
    wb_if.master s
);
    logic grant;     // 0 writer, 1 host
    logic busy;
    logic m0_req;
    logic m1_req;

    assign m0_req = m0.cyc && m0.stb;
    assign m1_req = m1.cyc && m1.stb;

    // Decide only when idle, then hold until the slave acks
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant <= 1'b0;
            busy  <= 1'b0;
        end else if (!busy) begin
            if (m0_req) begin
                grant <= 1'b0;
                busy  <= 1'b1;
            end else if (m1_req) begin
                grant <= 1'b1;
                busy  <= 1'b1;
            end
        end else if (s.ack) begin
            busy <= 1'b0;
        end
    end

    // Request mux
    assign s.cyc     = busy && (grant ? m1.cyc : m0.cyc);
    assign s.stb     = busy && (grant ? m1.stb : m0.stb);
    assign s.we      = grant ? m1.we      : m0.we;
    assign s.adr     = grant ? m1.adr     : m0.adr;
    assign s.dat_m2s = grant ? m1.dat_m2s : m0.dat_m2s;

    // Response only to the owner
    assign m0.ack     = busy && !grant && s.ack;
    assign m1.ack     = busy && grant && s.ack;
    assign m0.dat_s2m = grant ? '0 : s.dat_s2m;
    assign m1.dat_s2m = grant ? s.dat_s2m : '0;

endmodule

`default_nettype wire

//--- hdl/ofmap_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module ofmap_buffer (
    input  logic clk,
    input  logic rst_n,
    wb_if.slave  wb
);
    import acc_pkg::*;

    localparam int WIDX_W = $clog2(`ACC_BUF_WORDS);

    ofmap_word_u        mem [`ACC_BUF_WORDS];
    logic               req;
    logic [WIDX_W-1:0]  widx;

    assign req  = wb.cyc && wb.stb && !wb.ack;   // New request, not the acked one
    assign widx = wb.adr[WIDX_W+1:2];            // Word index

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            wb.ack <= 1'b0;
        else
            wb.ack <= req;   // Exactly one cycle
    end

    always_ff @(posedge clk) begin
        if (req && wb.we) mem[widx].raw <= wb.dat_m2s;
        if (req) wb.dat_s2m <= mem[widx].raw;    // Valid with ack
    end

endmodule

`default_nettype wire

//--- hdl/acc_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module acc_subsystem (
    input  logic                                     clk,
    input  logic                                     rst_n,
    input  logic [`ACC_PE_SIZE-1:0]                  psum_en_row_i,
    input  logic [`ACC_PE_SIZE*`ACC_PSUM_WIDTH-1:0]  psum_row_i,     // Lane 0 in low bits
    // Host Wishbone port
    input  logic                                     host_cyc_i,
    input  logic                                     host_stb_i,
    input  logic                                     host_we_i,
    input  logic [`ACC_ADDR_WIDTH-1:0]               host_adr_i,
    input  logic [`ACC_PE_SIZE*`ACC_DATA_WIDTH-1:0]  host_dat_i,
    output logic [`ACC_PE_SIZE*`ACC_DATA_WIDTH-1:0]  host_dat_o,
    output logic                                     host_ack_o,
    output logic                                     ofmap_valid_o,
    output logic                                     overflow_o
);
    import acc_pkg::*;

    logic        row_valid;
    ofmap_word_u row_data;

    wb_if wb_wr   ();   // Writer to arbiter
    wb_if wb_host ();   // Host to arbiter
    wb_if wb_mem  ();   // Arbiter to buffer

    // Host pins onto the master side
    assign wb_host.cyc     = host_cyc_i;
    assign wb_host.stb     = host_stb_i;
    assign wb_host.we      = host_we_i;
    assign wb_host.adr     = host_adr_i;
    assign wb_host.dat_m2s = host_dat_i;
    assign host_dat_o      = wb_host.dat_s2m;
    assign host_ack_o      = wb_host.ack;

    assign ofmap_valid_o = row_valid;

    psum_accumulator u_acc (
        .clk         (clk),
        .rst_n       (rst_n),
        .psum_en_i   (psum_en_row_i),
        .psum_row_i  (psum_row_i),
        .row_valid_o (row_valid),
        .row_data_o  (row_data)
    );

    ofmap_writer u_writer (
        .clk         (clk),
        .rst_n       (rst_n),
        .row_valid_i (row_valid),
        .row_data_i  (row_data),
        .wb          (wb_wr),
        .overflow_o  (overflow_o)
    );

    wb_arbiter u_arb (
        .clk   (clk),
        .rst_n (rst_n),
        .m0    (wb_wr),
        .m1    (wb_host),
        .s     (wb_mem)
    );

    ofmap_buffer u_buf (
        .clk   (clk),
        .rst_n (rst_n),
        .wb    (wb_mem)
    );

endmodule

`default_nettype wire

//--- testbench/acc_properties.sv
`timescale 1ns/1ps
`default_nettype none

module acc_properties (
    input logic clk,
    input logic rst_n,
    input logic stb_i,      // Strobe of the watched link
    input logic ack_i,      // Ack of the watched link
    input logic m0_ack_i,   // Writer ack, arbiter only
    input logic m1_ack_i    // Host ack, arbiter only
);
    int ack_twice_cnt = 0;
    int ack_no_stb_cnt = 0;
    int dual_ack_cnt = 0;
    int fail_total;

    assign fail_total = ack_twice_cnt + ack_no_stb_cnt + dual_ack_cnt;

    // Ack is a single cycle pulse
    a_ack_single: assert property (@(posedge clk) disable iff (!rst_n) ack_i |=> !ack_i)
        else begin
            ack_twice_cnt = ack_twice_cnt + 1;
            $error("ack high on two consecutive cycles");
        end

    a_ack_stb: assert property (@(posedge clk) disable iff (!rst_n) ack_i |-> stb_i)
        else begin
            ack_no_stb_cnt = ack_no_stb_cnt + 1;
            $error("ack without a pending strobe");
        end

    // Only the granted master gets the ack
    a_one_owner: assert property (@(posedge clk) disable iff (!rst_n) !(m0_ack_i && m1_ack_i))
        else begin
            dual_ack_cnt = dual_ack_cnt + 1;
            $error("arbiter acked both masters");
        end

endmodule

bind ofmap_buffer acc_properties u_buf_props (
    .clk(clk), .rst_n(rst_n), .stb_i(wb.stb), .ack_i(wb.ack),
    .m0_ack_i(1'b0), .m1_ack_i(1'b0)
);

// Writer side of the arbiter, the buffer side is watched above
bind wb_arbiter acc_properties u_arb_props (
    .clk(clk), .rst_n(rst_n), .stb_i(m0.stb), .ack_i(m0.ack),
    .m0_ack_i(m0.ack), .m1_ack_i(m1.ack)
);

`default_nettype wire

//--- testbench/tb_acc_subsystem.sv
`timescale 1ns/1ps
`default_nettype none

`include "acc_settings.svh"

module tb_acc_subsystem;
    localparam int LANES   = `ACC_PE_SIZE;
    localparam int ROWS    = `ACC_DEPTH;
    localparam int PASSES  = `ACC_PASSES;
    localparam int PW      = `ACC_PSUM_WIDTH;
    localparam int DW      = `ACC_DATA_WIDTH;
    localparam int WORD_W  = LANES * DW;
    localparam int ROW_W   = LANES * PW;
    localparam int TILES   = 2;
    localparam int ACK_LIMIT = 100;   // Host wait bound, cycles
    localparam int WATCHDOG_CYCLES = TILES * PASSES * ROWS * 7 + 400;

    logic                       clk;
    logic                       rst_n;
    logic [LANES-1:0]           psum_en_row;
    logic [ROW_W-1:0]           psum_row;
    logic                       host_cyc;
    logic                       host_stb;
    logic                       host_we;
    logic [`ACC_ADDR_WIDTH-1:0] host_adr;
    logic [WORD_W-1:0]          host_dat_wr;
    logic [WORD_W-1:0]          host_dat_rd;
    logic                       host_ack;
    logic                       ofmap_valid;
    logic                       overflow;

    logic [PW-1:0]     psum_data [PASSES*ROWS*LANES];   // Pass-major, lane fastest
    logic [WORD_W-1:0] expected [TILES][ROWS];
    logic              en_d [1:LANES-1];                // Lane 0 enable history
    logic [ROW_W-1:0]  row_d [1:LANES-1];               // Lane 0 row history
    logic [WORD_W-1:0] rd;
    integer            seed;
    int                errors;
    int                checks;
    int                pulses [TILES];
    int                early_pulses;
    int                tile_now;
    logic              last_pass_on;   // Current tile reached its final pass

    acc_subsystem dut (
        .clk(clk), .rst_n(rst_n), .psum_en_row_i(psum_en_row), .psum_row_i(psum_row),
        .host_cyc_i(host_cyc), .host_stb_i(host_stb), .host_we_i(host_we),
        .host_adr_i(host_adr), .host_dat_i(host_dat_wr), .host_dat_o(host_dat_rd),
        .host_ack_o(host_ack), .ofmap_valid_o(ofmap_valid), .overflow_o(overflow)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;   // 4 ns period
    end

    initial begin
        repeat (WATCHDOG_CYCLES) @(posedge clk);
        $display("ERROR: run timed out after %0d clock cycles", WATCHDOG_CYCLES);
        $display("*** FAILED ***");
        $finish;
    end

    task automatic check(input logic [WORD_W-1:0] actual, input logic [WORD_W-1:0] exp_val,
                         input string what);
        checks++;
        if (actual !== exp_val) begin
            errors++;
            $display("FAILED at %0t: %s, got %h expected %h", $time, what, actual, exp_val);
        end
    endtask

    // Sum of all passes per lane, then bits 15:8
    function automatic logic [WORD_W-1:0] model_row(input int tile, input int entry);
        logic [PW-1:0]     key;
        logic [PW-1:0]     sum;
        logic [WORD_W-1:0] word;
        key  = (tile == 1) ? PW'(2) : '0;   // Second tile XOR-ed with its number
        word = '0;
        for (int k = 0; k < LANES; k++) begin
            sum = '0;
            for (int p = 0; p < PASSES; p++)
                sum = sum + (psum_data[(p*ROWS + entry)*LANES + k] ^ key);
            word[k*DW +: DW] = sum[`ACC_SLICE_MSB -: DW];
        end
        return word;
    endfunction

    // One clock of lane 0 input, lane j replays it j cycles later
    task automatic drive_cycle(input logic en, input logic [ROW_W-1:0] row);
        logic [LANES-1:0] en_vec;
        logic [ROW_W-1:0] row_vec;
        @(posedge clk);
        en_vec[0]      = en;
        row_vec[PW-1:0] = row[PW-1:0];
        for (int j = 1; j < LANES; j++) begin
            en_vec[j]           = en_d[j];
            row_vec[j*PW +: PW] = row_d[j][j*PW +: PW];
        end
        psum_en_row <= en_vec;
        psum_row    <= row_vec;
        for (int j = LANES-1; j > 1; j--) begin
            en_d[j]  = en_d[j-1];
            row_d[j] = row_d[j-1];
        end
        en_d[1]  = en;
        row_d[1] = row;
    endtask

    task automatic run_tile(input int tile);
        logic [ROW_W-1:0] row;
        logic [PW-1:0]    key;
        int               gap;
        key          = (tile == 1) ? PW'(2) : '0;
        tile_now     = tile;
        last_pass_on = 1'b0;
        for (int p = 0; p < PASSES; p++) begin
            for (int e = 0; e < ROWS; e++) begin
                gap = $random(seed) & 3;   // 0 to 3 idle cycles
                repeat (gap) drive_cycle(1'b0, '0);
                for (int k = 0; k < LANES; k++)
                    row[k*PW +: PW] = psum_data[(p*ROWS + e)*LANES + k] ^ key;
                if (p == PASSES-1 && e == 0)
                    last_pass_on = 1'b1;
                drive_cycle(1'b1, row);
            end
        end
        repeat (LANES) drive_cycle(1'b0, '0);   // Flush the skewed lanes
    endtask

    task automatic wait_rows(input int tile);
        while (pulses[tile] < ROWS) @(negedge clk);
    endtask

    // cyc drops for one cycle between queued writes, so three idle cycles means drained
    task automatic wait_writer_idle();
        int idle;
        idle = 0;
        while (idle < 3) begin
            @(negedge clk);
            idle = dut.wb_wr.cyc ? 0 : idle + 1;
        end
    endtask

    task automatic host_access(input logic we, input int word, input logic [WORD_W-1:0] wdata,
                               output logic [WORD_W-1:0] rdata);
        int waited;
        waited = 0;
        @(posedge clk);
        host_cyc    <= 1'b1;
        host_stb    <= 1'b1;
        host_we     <= we;
        host_adr    <= `ACC_ADDR_WIDTH'(word * 4);   // Word to byte address
        host_dat_wr <= wdata;
        @(negedge clk);
        while (!host_ack && waited < ACK_LIMIT) begin
            @(negedge clk);
            waited++;
        end
        if (!host_ack) begin
            errors++;
            $display("ERROR: host request to word %0d got no ack in %0d cycles", word, ACK_LIMIT);
        end
        rdata = host_dat_rd;
        @(posedge clk);
        host_cyc <= 1'b0;   // Strobe drops the cycle after ack
        host_stb <= 1'b0;
        host_we  <= 1'b0;
    endtask

    task automatic read_word(input int word, input logic [WORD_W-1:0] exp_val, input string what);
        logic [WORD_W-1:0] data;
        host_access(1'b0, word, '0, data);
        check(data, exp_val, what);
    endtask

    // Row pulse counter, sampled away from the active edge
    always @(negedge clk) begin
        if (rst_n && ofmap_valid) begin
            if (!last_pass_on)
                early_pulses++;
            pulses[tile_now]++;
        end
    end

    initial begin
        seed         = 32'h05e9_2086;
        errors       = 0;
        checks       = 0;
        early_pulses = 0;
        tile_now     = 0;
        last_pass_on = 1'b0;
        pulses[0]    = 0;
        pulses[1]    = 0;
        rst_n        = 1'b0;
        psum_en_row  = '0;
        psum_row     = '0;
        host_cyc     = 1'b0;
        host_stb     = 1'b0;
        host_we      = 1'b0;
        host_adr     = '0;
        host_dat_wr  = '0;
        for (int j = 1; j < LANES; j++) begin
            en_d[j]  = 1'b0;
            row_d[j] = '0;
        end
        $readmemh("testbench/acc_testdata.txt", psum_data);
        for (int t = 0; t < TILES; t++)
            for (int e = 0; e < ROWS; e++)
                expected[t][e] = model_row(t, e);
        repeat (10) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check(WORD_W'(overflow), '0, "overflow after reset");

        run_tile(0);
        wait_rows(0);
        wait_writer_idle();
        check(WORD_W'(pulses[0]), WORD_W'(ROWS), "tile 1 row pulse count");
        for (int w = 0; w < ROWS; w++)
            read_word(w, expected[0][w], $sformatf("tile 1 word %0d", w));

        last_pass_on = 1'b0;
        fork
            begin
                run_tile(1);
                wait_rows(1);
            end
            begin
                while (!last_pass_on) @(negedge clk);   // Writer is about to start
                for (int r = 0; r < 2*ROWS; r++)
                    read_word(r % ROWS, expected[0][r % ROWS],
                              $sformatf("word %0d during tile 2", r % ROWS));
            end
        join
        wait_writer_idle();
        check(WORD_W'(pulses[1]), WORD_W'(ROWS), "tile 2 row pulse count");
        check(WORD_W'(pulses[0]), WORD_W'(ROWS), "tile 1 row pulse count at end");
        check(WORD_W'(early_pulses), '0, "row pulses before the final pass");
        for (int w = 0; w < ROWS; w++)
            read_word(ROWS + w, expected[1][w], $sformatf("tile 2 word %0d", ROWS + w));
        for (int w = 0; w < ROWS; w++)
            read_word(w, expected[0][w], $sformatf("tile 1 word %0d after tile 2", w));

        host_access(1'b1, 40, 32'hc35a_96e1, rd);
        read_word(40, 32'hc35a_96e1, "host write of word 40");
        check(WORD_W'(overflow), '0, "overflow at end of run");

        if (dut.u_buf.u_buf_props.fail_total + dut.u_arb.u_arb_props.fail_total != 0) begin
            errors = errors + dut.u_buf.u_buf_props.fail_total + dut.u_arb.u_arb_props.fail_total;
            $display("ERROR: Wishbone handshake assertions failed");
        end
        $display("Checks: %0d, errors: %0d", checks, errors);
        if (errors == 0)
            $display("*** PASSED ***");
        else
            $display("*** FAILED ***");
        $finish;
    end

endmodule

`default_nettype wire

//--- verilog.f
+incdir+include
hdl/acc_pkg.sv
hdl/wb_if.sv
hdl/psum_fifo.sv
hdl/psum_accumulator.sv
hdl/ofmap_writer.sv
hdl/wb_arbiter.sv
hdl/ofmap_buffer.sv
hdl/acc_subsystem.sv
testbench/acc_properties.sv
testbench/tb_acc_subsystem.sv

//--- run_sim.sh
#!/usr/bin/env bash
# Build and run the accumulator subsystem testbench with Verilator
cd "$(dirname "$0")" || exit 1

TOP=tb_acc_subsystem
LOG=sim.log

verilator --binary --timing --assert -j 0 --top-module "$TOP" -f verilog.f -o "V$TOP"
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

# Keep running past assertion errors so the testbench can report them
"./obj_dir/V$TOP" +verilator+error+limit+100 > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -qF "*** PASSED ***" "$LOG"; then
    echo "Simulation result: pass"
    exit 0
fi
echo "Simulation result: fail"
exit 1

//--- testbench/acc_testdata.txt
// Columns: lane 0, lane 1, lane 2, lane 3 partial sums, 32-bit hex
// One line per (pass, entry), pass-major: pass 0 entries 0-7, then pass 1, then pass 2
00001a2b 00000f3c fffff812 00002201
000003c4 00001177 00000a90 ffffe5d0
00002f00 000000ff 00001380 00000c41
fffffe01 00003456 00000777 00001b1b
00000d0d 00002233 fffff00f 00000909
00001111 00000abc ffffff80 00002020
00000505 00001e1e 00000c0c 00003303
00002a5a fffff1f1 00000808 00001234
00000456 00002001 00000f0f fffffa00
00001234 00000567 fffff9f9 00000303
fffff800 00000a0a 00001c1c 00000e0e
00000999 00000444 00002121 00000101
00001313 fffffc3c 00000606 00002e2e
00000f00 00000707 00001a1a ffffef01
00003001 00000202 00000d80 00000b0b
00000111 00001818 fffffd0d 00000c70
00000ff0 ffffff01 00000404 00001919
00000220 00002c2c 00000330 00000a55
00001a01 00000990 fffff701 00000606
00000123 00000f0f 00001515 00002345
fffffe80 00000707 00000b0b 00000c0c
00002222 00001010 00000c40 00000808
00000170 fffffa5a 00000e0e 00001111
00000909 00000303 00001717 fffff0f0
